// File: logic/pe_cfg_pkg.sv
package pe_cfg_pkg;

    ////////////////////////////////////////
    // Core dimensions
    ////////////////////////////////////////

    // One signed real value
    localparam int DATA_WIDTH = 16;

    // Lanes in the processing element bank
    localparam int PE_NUM = 8;

    // Rows summed per block
    localparam int ROWS = 16;

    // Elements held by each buffer
    localparam int DEPTH = PE_NUM * ROWS;

    // Full product plus headroom for ROWS additions
    localparam int ACC_WIDTH = 2 * DATA_WIDTH + $clog2(ROWS);

    // Counter widths
    localparam int LANE_W = $clog2(PE_NUM);
    localparam int ROW_W  = $clog2(ROWS);

endpackage

// File: logic/pe_types_pkg.sv
package pe_types_pkg;

    import pe_cfg_pkg::*;

    ////////////////////////////////////////
    // Element types
    ////////////////////////////////////////

    // Real coefficient
    typedef logic signed [DATA_WIDTH-1:0] coef_t;

    // Complex sample, real part in the upper half
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] re;
        logic signed [DATA_WIDTH-1:0] im;
    } cplx_t;

    // Complex running sum
    typedef struct packed {
        logic signed [ACC_WIDTH-1:0] re;
        logic signed [ACC_WIDTH-1:0] im;
    } cplx_acc_t;

    ////////////////////////////////////////
    // Row types, lane 0 in the low bits
    ////////////////////////////////////////

    // One row of coefficients, 128 bits
    typedef coef_t [PE_NUM-1:0] coef_row_t;

    // One row of samples, 256 bits
    typedef cplx_t [PE_NUM-1:0] samp_row_t;

    // One vector of lane sums, 576 bits
    typedef cplx_acc_t [PE_NUM-1:0] acc_row_t;

endpackage

// File: logic/sipo_buffer.sv
`timescale 1ns/1ns

module sipo_buffer import pe_cfg_pkg::*; #(
    parameter type elem_t = logic [DATA_WIDTH-1:0]
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ce,
    input  logic                     s_in_v,
    input  elem_t                    s_in,
    input  logic                     shift_v,
    output logic                     p_out_v,
    output elem_t [PE_NUM-1:0]       p_out
);

    // Storage, one entry per row
    elem_t [PE_NUM-1:0] mem [ROWS];

    // Write side walks lanes first, then rows
    logic [LANE_W-1:0] wr_lane;
    logic [ROW_W-1:0]  wr_row;

    // Read side walks whole rows
    logic [ROW_W-1:0]  rd_row;

    logic wr_en;
    logic rd_en;
    logic wr_lane_last;
    logic wr_row_last;
    logic rd_row_last;

    ////////////////////////////////////////
    // Strobes and wrap points
    ////////////////////////////////////////

    assign wr_en = ce & s_in_v;
    assign rd_en = ce & shift_v;

    assign wr_lane_last = (wr_lane == LANE_W'(PE_NUM - 1));
    assign wr_row_last  = (wr_row == ROW_W'(ROWS - 1));
    assign rd_row_last  = (rd_row == ROW_W'(ROWS - 1));

    ////////////////////////////////////////
    // Serial load
    ////////////////////////////////////////

    // Element k goes to row k / PE_NUM, lane k % PE_NUM
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row][wr_lane] <= s_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_lane <= '0;
            wr_row  <= '0;
        end else if (wr_en) begin
            if (wr_lane_last) begin
                wr_lane <= '0;
                // Wraps at DEPTH so the next block overwrites row 0
                wr_row  <= wr_row_last ? '0 : wr_row + 1'b1;
            end else begin
                wr_lane <= wr_lane + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Parallel read
    ////////////////////////////////////////

    // Row register, updated only on a shift
    always_ff @(posedge clk) begin
        if (rd_en) begin
            p_out <= mem[rd_row];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_row  <= '0;
            p_out_v <= 1'b0;
        end else if (ce) begin
            // One cycle of valid per shift cycle
            p_out_v <= shift_v;
            if (shift_v) begin
                rd_row <= rd_row_last ? '0 : rd_row + 1'b1;
            end
        end
    end

endmodule

// File: logic/pe_mac_array.sv
`timescale 1ns/1ns

module pe_mac_array import pe_cfg_pkg::*, pe_types_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ce,
    input  logic      row_v,
    input  coef_row_t coef_row,
    input  samp_row_t samp_row,
    output logic      acc_v,
    output acc_row_t  acc
);

    // Position of the incoming row inside its block
    logic [ROW_W-1:0] row_cnt;

    logic first_row;
    logic last_row;
    logic acc_en;

    // Working sums of the block in progress
    acc_row_t sum_q;

    // Per lane products and updated sums
    acc_row_t prod;
    acc_row_t sum_d;

    ////////////////////////////////////////
    // Block position
    ////////////////////////////////////////

    assign acc_en    = ce & row_v;
    assign first_row = (row_cnt == '0);
    assign last_row  = (row_cnt == ROW_W'(ROWS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (acc_en) begin
            row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Lane datapath
    ////////////////////////////////////////

    // Operands are signed, so the 36 bit context sign extends them
    always_comb begin
        for (int i = 0; i < PE_NUM; i++) begin
            prod[i].re = coef_row[i] * samp_row[i].re;
            prod[i].im = coef_row[i] * samp_row[i].im;
        end
    end

    // First row of a block starts a fresh sum
    always_comb begin
        for (int i = 0; i < PE_NUM; i++) begin
            if (first_row) begin
                sum_d[i] = prod[i];
            end else begin
                sum_d[i].re = sum_q[i].re + prod[i].re;
                sum_d[i].im = sum_q[i].im + prod[i].im;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            sum_q <= sum_d;
        end
    end

    ////////////////////////////////////////
    // Block result
    ////////////////////////////////////////

    // Completed sums move out, working sums are free for the next block
    always_ff @(posedge clk) begin
        if (acc_en && last_row) begin
            acc <= sum_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_v <= 1'b0;
        end else if (ce) begin
            // Pulse held while ce is low
            acc_v <= row_v & last_row;
        end
    end

endmodule

// File: logic/pe_core.sv
`timescale 1ns/1ns

module pe_core import pe_types_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ce,
    input  logic     coef_in_v,
    input  coef_t    coef_in,
    input  logic     samp_in_v,
    input  cplx_t    samp_in,
    input  logic     shift_v,
    output logic     acc_out_v,
    output acc_row_t acc_out
);

    ////////////////////////////////////////
    // Row buffers
    ////////////////////////////////////////

    logic      coef_row_v;
    coef_row_t coef_row;

    // Valid of the sample side, watched by the assertions only
    logic      samp_row_v;
    samp_row_t samp_row;

    // Real coefficients
    sipo_buffer #(
        .elem_t  (coef_t)
    ) coef_buf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ce      (ce),
        .s_in_v  (coef_in_v),
        .s_in    (coef_in),
        .shift_v (shift_v),
        .p_out_v (coef_row_v),
        .p_out   (coef_row)
    );

    // Complex samples, same shift so rows stay aligned
    sipo_buffer #(
        .elem_t  (cplx_t)
    ) samp_buf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ce      (ce),
        .s_in_v  (samp_in_v),
        .s_in    (samp_in),
        .shift_v (shift_v),
        .p_out_v (samp_row_v),
        .p_out   (samp_row)
    );

    ////////////////////////////////////////
    // MAC bank
    ////////////////////////////////////////

    pe_mac_array mac_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ce       (ce),
        .row_v    (coef_row_v),
        .coef_row (coef_row),
        .samp_row (samp_row),
        .acc_v    (acc_out_v),
        .acc      (acc_out)
    );

endmodule

// File: verif/pe_core_sva.sv
`timescale 1ns/1ns

module pe_core_sva import pe_types_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     ce,
    input logic     coef_row_v,
    input logic     samp_row_v,
    input logic     acc_out_v,
    input acc_row_t acc_out
);

    ////////////////////////////////////////
    // Reset and buffer alignment
    ////////////////////////////////////////

    // Synchronous reset clears the pulse on the next edge
    rst_quiet: assert property (@(posedge clk) !rst_n |=> !acc_out_v)
        else $error("acc_out_v high while in reset");

    // Both buffers share shift_v and ce
    rows_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        coef_row_v == samp_row_v)
        else $error("coefficient and sample rows out of step");

    ////////////////////////////////////////
    // Output pulse
    ////////////////////////////////////////

    // Blocks are ROWS rows long, so pulses never touch
    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (ce && acc_out_v) |=> !acc_out_v)
        else $error("acc_out_v high on two consecutive enabled cycles");

    // Frozen core keeps its sums
    frozen_sums: assert property (@(posedge clk) disable iff (!rst_n)
        !ce |=> $stable(acc_out))
        else $error("acc_out changed while ce was low");

endmodule

bind pe_core pe_core_sva sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ce         (ce),
    .coef_row_v (coef_row_v),
    .samp_row_v (samp_row_v),
    .acc_out_v  (acc_out_v),
    .acc_out    (acc_out)
);

// File: verif/tb_pe_core.sv
`timescale 1ns/1ns

module tb_pe_core
    import pe_cfg_pkg::*, pe_types_pkg::*;
();

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;
    // Pulse shows one edge after the edge that took the last shift
    localparam int ACC_LAT      = 1;
    localparam int WAIT_LIMIT   = 100;
    localparam int QUIET_CYCLES = 20;
    localparam int RUN_LIMIT    = 20000;

    logic     clk;
    logic     rst_n;
    logic     ce;
    logic     coef_in_v;
    coef_t    coef_in;
    logic     samp_in_v;
    cplx_t    samp_in;
    logic     shift_v;
    logic     acc_out_v;
    acc_row_t acc_out;

    // Block contents as loaded, element k at index k
    coef_t coef_mem [DEPTH];
    cplx_t samp_mem [DEPTH];

    // Log of every acc_out_v pulse
    int       pulse_cyc_q [$];
    acc_row_t pulse_acc_q [$];

    int cyc = 0;
    int last_shift_cyc = 0;
    int err_cnt = 0;
    int chk_cnt = 0;
    int test_err_start = 0;

    pe_core dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ce        (ce),
        .coef_in_v (coef_in_v),
        .coef_in   (coef_in),
        .samp_in_v (samp_in_v),
        .samp_in   (samp_in),
        .shift_v   (shift_v),
        .acc_out_v (acc_out_v),
        .acc_out   (acc_out)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (rst_n && acc_out_v) begin
            pulse_cyc_q.push_back(cyc);
            pulse_acc_q.push_back(acc_out);
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run did not finish within %0d cycles", RUN_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_valid(input string name, input bit got, input bit exp);
        chk_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_acc_row(input string name, input acc_row_t got, input acc_row_t exp);
        chk_cnt++;
        for (int i = 0; i < PE_NUM; i++) begin
            if (got[i].re !== exp[i].re) begin
                err_cnt++;
                $display("Fail %s[%0d].re got %h expected %h", name, i, got[i].re, exp[i].re);
            end
            if (got[i].im !== exp[i].im) begin
                err_cnt++;
                $display("Fail %s[%0d].im got %h expected %h", name, i, got[i].im, exp[i].im);
            end
        end
    endtask

    ////////////////////////////////////////
    // Reference model and stimulus data
    ////////////////////////////////////////

    // Lane sum over the block of coef times sample, 64 bit then cut to ACC_WIDTH
    function automatic acc_row_t model_sums();
        acc_row_t sums;
        longint   re_sum;
        longint   im_sum;
        int       k;
        for (int lane = 0; lane < PE_NUM; lane++) begin
            re_sum = 0;
            im_sum = 0;
            for (int r = 0; r < ROWS; r++) begin
                k = r * PE_NUM + lane;
                re_sum += longint'(coef_mem[k]) * longint'(samp_mem[k].re);
                im_sum += longint'(coef_mem[k]) * longint'(samp_mem[k].im);
            end
            sums[lane].re = re_sum[ACC_WIDTH-1:0];
            sums[lane].im = im_sum[ACC_WIDTH-1:0];
        end
        return sums;
    endfunction

    task automatic fill_ramp();
        for (int k = 0; k < DEPTH; k++) begin
            coef_mem[k]    = coef_t'(k + 1);
            samp_mem[k].re = 16'(k);
            samp_mem[k].im = 16'(-k);
        end
    endtask

    task automatic fill_random(input bit extremes);
        logic [31:0] rnd;
        for (int k = 0; k < DEPTH; k++) begin
            rnd = $urandom;
            coef_mem[k] = rnd[15:0];
            rnd = $urandom;
            samp_mem[k].re = rnd[15:0];
            samp_mem[k].im = rnd[31:16];
        end
        // Lanes 0 to 2 carry the largest products of either sign
        if (extremes) begin
            for (int r = 0; r < ROWS; r++) begin
                coef_mem[r * PE_NUM]        = 16'h8000;
                samp_mem[r * PE_NUM]        = '{re: 16'h8000, im: 16'h7fff};
                coef_mem[r * PE_NUM + 1]    = 16'h7fff;
                samp_mem[r * PE_NUM + 1]    = '{re: 16'h7fff, im: 16'h8000};
                coef_mem[r * PE_NUM + 2]    = 16'h8000;
                samp_mem[r * PE_NUM + 2]    = '{re: 16'h7fff, im: 16'h8000};
            end
        end
    endtask

    ////////////////////////////////////////
    // Drivers and waits
    ////////////////////////////////////////

    task automatic load_block();
        for (int k = 0; k < DEPTH; k++) begin
            @(negedge clk);
            coef_in_v = 1'b1;
            samp_in_v = 1'b1;
            coef_in   = coef_mem[k];
            samp_in   = samp_mem[k];
        end
        @(negedge clk);
        coef_in_v = 1'b0;
        samp_in_v = 1'b0;
    endtask

    // With keep set, shift_v is left high for the caller
    task automatic run_shift(input int n, input bit keep);
        repeat (n) begin
            @(negedge clk);
            shift_v = 1'b1;
        end
        if (!keep) begin
            @(negedge clk);
            shift_v = 1'b0;
            last_shift_cyc = cyc;
        end
    endtask

    // Shift requested but frozen by ce
    task automatic pause_ce(input int n);
        repeat (n) begin
            @(negedge clk);
            ce      = 1'b0;
            shift_v = 1'b1;
        end
        @(negedge clk);
        ce      = 1'b1;
        shift_v = 1'b0;
        // A pending row moves on at the edge after ce returns
        last_shift_cyc = cyc;
    endtask

    task automatic wait_acc(input int first, input int count);
        int waited;
        waited = 0;
        while (pulse_cyc_q.size() < first + count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (pulse_cyc_q.size() < first + count) begin
            err_cnt++;
            $display("No acc_out_v pulse within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Pulse count, timing from the last shift, then the sums
    task automatic check_block_result(input int first, input int count, input acc_row_t exp);
        int seen;
        int want_cyc;
        wait_acc(first, count);
        repeat (QUIET_CYCLES) @(negedge clk);
        seen = pulse_cyc_q.size() - first;
        chk_cnt++;
        if (seen != count) begin
            err_cnt++;
            $display("Expected %0d acc_out_v pulses but saw %0d", count, seen);
        end
        for (int j = 0; j < count && j < seen; j++) begin
            want_cyc = last_shift_cyc + ACC_LAT - (count - 1 - j) * ROWS;
            chk_cnt++;
            if (pulse_cyc_q[first + j] != want_cyc) begin
                err_cnt++;
                $display("Pulse %0d arrived at cycle %0d instead of cycle %0d",
                         j, pulse_cyc_q[first + j], want_cyc);
            end
            check_acc_row("acc_out", pulse_acc_q[first + j], exp);
        end
    endtask

    task automatic begin_test();
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d errors", name, err_cnt - test_err_start);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic idle_after_reset();
        begin_test();
        repeat (50) begin
            @(negedge clk);
            check_valid("acc_out_v", acc_out_v, 1'b0);
        end
        end_test("idle_after_reset");
    endtask

    task automatic ramp_block();
        int first;
        begin_test();
        fill_ramp();
        load_block();
        first = pulse_cyc_q.size();
        run_shift(ROWS, 1'b0);
        check_valid("acc_out_v", acc_out_v, 1'b0);
        check_block_result(first, 1, model_sums());
        end_test("ramp_block");
    endtask

    task automatic random_block();
        int first;
        begin_test();
        fill_random(1'b1);
        load_block();
        first = pulse_cyc_q.size();
        run_shift(ROWS, 1'b0);
        check_block_result(first, 1, model_sums());
        end_test("random_block");
    endtask

    // Same data, read with a ce freeze and a shift gap
    task automatic paused_block();
        int first;
        begin_test();
        first = pulse_cyc_q.size();
        run_shift(3, 1'b1);
        pause_ce(5);
        run_shift(5, 1'b0);
        repeat (6) @(negedge clk);
        // Freeze again with the last row of the block pending
        run_shift(8, 1'b1);
        pause_ce(4);
        check_block_result(first, 1, model_sums());
        end_test("paused_block");
    endtask

    task automatic back_to_back();
        int first;
        begin_test();
        first = pulse_cyc_q.size();
        run_shift(2 * ROWS, 1'b0);
        check_block_result(first, 2, model_sums());
        end_test("back_to_back");
    endtask

    task automatic reload_block();
        int first;
        begin_test();
        fill_random(1'b0);
        load_block();
        first = pulse_cyc_q.size();
        run_shift(ROWS, 1'b0);
        check_block_result(first, 1, model_sums());
        end_test("reload_block");
    endtask

    initial begin
        rst_n     = 1'b0;
        ce        = 1'b1;
        coef_in_v = 1'b0;
        coef_in   = '0;
        samp_in_v = 1'b0;
        samp_in   = '0;
        shift_v   = 1'b0;
        void'($urandom(32'h5a4b8939));

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        ramp_block();
        random_block();
        paused_block();
        back_to_back();
        reload_block();

        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/pe_cfg_pkg.sv
logic/pe_types_pkg.sv
logic/sipo_buffer.sv
logic/pe_mac_array.sv
logic/pe_core.sv
verif/pe_core_sva.sv
verif/tb_pe_core.sv

// File: run.sh
#!/bin/sh
# Compile the pe_core testbench with Verilator, run it into sim.log and check the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_pe_core \
    -o sim_pe_core \
    && ./obj_dir/sim_pe_core > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
